/* hdl/lcd_pkg.sv */
package lcd_pkg;

    // Wishbone widths
    localparam int WB_AW = 30;  // Word address
    localparam int WB_DW = 32;

    // Display write cycle length in clocks
    localparam int CMD_DELAY = 50;
    localparam int CNT_W     = $clog2(CMD_DELAY + 1);

    localparam int BUSY_BIT = 7;  // Busy flag position in a status read

    // Power-up command list
    localparam int INIT_LEN = 4;
    localparam int IDX_W    = $clog2(INIT_LEN);

    localparam logic [7:0] INIT_CMDS [INIT_LEN] = '{
        8'h38,  // Function set 8-bit 2 lines
        8'h0C,  // Display on with cursor off
        8'h01,  // Clear display
        8'h06   // Entry mode increment without shift
    };

endpackage

/* hdl/lcd_hd44780_bus.sv */
`default_nettype none

module lcd_hd44780_bus import lcd_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_wb_cyc,
    input  logic             i_wb_stb,
    input  logic             i_wb_we,
    input  logic [WB_AW-1:0] i_wb_addr,
    input  logic [WB_DW-1:0] i_wb_data,
    input  logic [7:0]       i_disp_data,
    output logic             o_wb_ack,
    output logic             o_wb_stall,
    output logic [WB_DW-1:0] o_wb_data,
    output logic [7:0]       o_disp_data,
    output logic             o_disp_rw,
    output logic             o_disp_en,
    output logic             o_disp_rs,
    output logic             o_disp_on,
    output logic             o_disp_blon
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_EN_LOW,
        S_EN_HIGH,
        S_RESP
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;        // Clocks since the cycle started
    logic [7:0]       disp_meta;
    logic [7:0]       disp_sync;
    logic             accept;

    // Panel power and backlight stay on
    assign o_disp_on   = 1'b1;
    assign o_disp_blon = 1'b1;

    assign o_wb_stall = !i_rst_n || (state != S_IDLE);
    assign o_wb_ack   = (state == S_RESP) && i_wb_cyc;
    assign accept     = i_wb_cyc && i_wb_stb && !o_wb_stall;

    // Two-flop synchroniser on the display data pins
    always_ff @(posedge i_clk) begin
        disp_meta <= i_disp_data;
        disp_sync <= disp_meta;
    end

    // Captured write byte and read return word
    always_ff @(posedge i_clk) begin
        if (accept) begin
            if (i_wb_we) begin
                o_disp_data <= i_wb_data[7:0];
                o_wb_data   <= '0;
            end else begin
                o_wb_data <= {{(WB_DW - 8){1'b0}}, disp_sync};
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state     <= S_IDLE;
            cnt       <= '0;
            o_disp_en <= 1'b0;
            o_disp_rw <= 1'b1;   // Idle in read direction
            o_disp_rs <= 1'b0;
        end else if ((state != S_IDLE) && !i_wb_cyc) begin
            // Master dropped cyc so the cycle ends
            state     <= S_IDLE;
            o_disp_en <= 1'b0;
            o_disp_rw <= 1'b1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        cnt       <= '0;
                        o_disp_rs <= i_wb_addr[0];  // RS from word address bit 0
                        if (i_wb_we) begin
                            o_disp_rw <= 1'b0;
                            state     <= S_EN_LOW;
                        end else begin
                            state <= S_RESP;        // Pins already sampled
                        end
                    end
                end
                S_EN_LOW: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(CMD_DELAY / 2 - 1)) begin
                        o_disp_en <= 1'b1;
                        state     <= S_EN_HIGH;
                    end
                end
                S_EN_HIGH: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(CMD_DELAY - 1)) begin
                        o_disp_en <= 1'b0;          // Display latches on this edge
                        o_disp_rw <= 1'b1;
                    end
                    // One hold clock after the falling edge
                    if (cnt == CNT_W'(CMD_DELAY)) begin
                        state <= S_RESP;
                    end
                end
                default: begin
                    state <= S_IDLE;                // Ack goes out this cycle
                end
            endcase
        end
    end

    // Enable only pulses while the bus drives the pins
    a_en_with_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_disp_en |-> !o_disp_rw);

    // Setup phase moves only forward to the enable phase
    a_state_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ((state == S_EN_LOW) && i_wb_cyc) |=> (state inside {S_EN_LOW, S_EN_HIGH}));

endmodule

`default_nettype wire

/* hdl/wb_rr_arbiter.sv */
`default_nettype none

module wb_rr_arbiter import lcd_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst_n,
    // Master 0
    input  logic             i_m0_cyc,
    input  logic             i_m0_stb,
    input  logic             i_m0_we,
    input  logic [WB_AW-1:0] i_m0_addr,
    input  logic [WB_DW-1:0] i_m0_data,
    output logic             o_m0_ack,
    output logic             o_m0_stall,
    output logic [WB_DW-1:0] o_m0_data,
    // Master 1
    input  logic             i_m1_cyc,
    input  logic             i_m1_stb,
    input  logic             i_m1_we,
    input  logic [WB_AW-1:0] i_m1_addr,
    input  logic [WB_DW-1:0] i_m1_data,
    output logic             o_m1_ack,
    output logic             o_m1_stall,
    output logic [WB_DW-1:0] o_m1_data,
    // Slave
    input  logic             i_s_ack,
    input  logic             i_s_stall,
    input  logic [WB_DW-1:0] i_s_data,
    output logic             o_s_cyc,
    output logic             o_s_stb,
    output logic             o_s_we,
    output logic [WB_AW-1:0] o_s_addr,
    output logic [WB_DW-1:0] o_s_data
);

    logic busy;       // Grant held for one transfer
    logic owner;
    logic last;       // Master served most recently
    logic winner;
    logic sel;
    logic owner_cyc;

    // Both asking means the one not served last wins
    assign winner    = (i_m0_cyc && i_m1_cyc) ? !last : i_m1_cyc;
    assign sel       = busy ? owner : winner;
    assign owner_cyc = owner ? i_m1_cyc : i_m0_cyc;

    // Request path follows the grant with no added cycle
    assign o_s_cyc  = sel ? i_m1_cyc  : i_m0_cyc;
    assign o_s_stb  = sel ? i_m1_stb  : i_m0_stb;
    assign o_s_we   = sel ? i_m1_we   : i_m0_we;
    assign o_s_addr = sel ? i_m1_addr : i_m0_addr;
    assign o_s_data = sel ? i_m1_data : i_m0_data;

    // Loser sees stall and never an ack
    assign o_m0_stall = sel ? 1'b1 : i_s_stall;
    assign o_m1_stall = sel ? i_s_stall : 1'b1;
    assign o_m0_ack   = i_s_ack && !sel;
    assign o_m1_ack   = i_s_ack && sel;
    assign o_m0_data  = i_s_data;   // Qualified by ack
    assign o_m1_data  = i_s_data;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy  <= 1'b0;
            owner <= 1'b0;
            last  <= 1'b1;    // Master 0 goes first
        end else if (!busy) begin
            if (i_m0_cyc || i_m1_cyc) begin
                busy  <= 1'b1;
                owner <= winner;
            end
        end else if (i_s_ack) begin
            busy <= 1'b0;
            last <= owner;
        end else if (!owner_cyc) begin
            busy <= 1'b0;     // Aborted transfer
        end
    end

    a_ack_m0_granted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_m0_ack |-> (busy && !owner));

    a_ack_m1_granted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_m1_ack |-> (busy && owner));

endmodule

`default_nettype wire

/* hdl/lcd_init_sequencer.sv */
`default_nettype none

module lcd_init_sequencer import lcd_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_wb_ack,
    input  logic             i_wb_stall,
    input  logic [WB_DW-1:0] i_wb_data,
    output logic             o_wb_cyc,
    output logic             o_wb_stb,
    output logic             o_wb_we,
    output logic [WB_AW-1:0] o_wb_addr,
    output logic [WB_DW-1:0] o_wb_data,
    output logic             o_init_done
);

    typedef enum logic [2:0] {
        S_START,
        S_WR_REQ,
        S_WR_WAIT,
        S_RD_REQ,
        S_RD_WAIT,
        S_DONE
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] idx;       // Current entry of INIT_CMDS
    logic             last_cmd;
    logic             busy_flag;

    assign last_cmd  = (idx == IDX_W'(INIT_LEN - 1));
    assign busy_flag = i_wb_data[BUSY_BIT];

    // Bus outputs decoded from the state
    assign o_wb_cyc  = (state != S_START) && (state != S_DONE);
    assign o_wb_stb  = (state == S_WR_REQ) || (state == S_RD_REQ);
    assign o_wb_we   = (state == S_WR_REQ) || (state == S_WR_WAIT);
    assign o_wb_addr = '0;       // RS 0 for commands and status
    assign o_wb_data = {{(WB_DW - 8){1'b0}}, INIT_CMDS[idx]};

    assign o_init_done = (state == S_DONE);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= S_START;
            idx   <= '0;
        end else begin
            case (state)
                S_START: begin
                    state <= S_WR_REQ;
                end
                S_WR_REQ: begin
                    if (!i_wb_stall) begin
                        state <= S_WR_WAIT;
                    end
                end
                S_WR_WAIT: begin
                    if (i_wb_ack) begin
                        state <= S_RD_REQ;    // Start polling the busy flag
                    end
                end
                S_RD_REQ: begin
                    if (!i_wb_stall) begin
                        state <= S_RD_WAIT;
                    end
                end
                S_RD_WAIT: begin
                    if (i_wb_ack) begin
                        if (busy_flag) begin
                            state <= S_RD_REQ;          // Still busy so poll again
                        end else if (last_cmd) begin
                            state <= S_DONE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= S_WR_REQ;
                        end
                    end
                end
                default: begin
                    state <= S_DONE;                    // Stays here until reset
                end
            endcase
        end
    end

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_stb |-> o_wb_cyc);

    // A stalled request is held unchanged
    a_req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_wb_stb && i_wb_stall) |=>
            (o_wb_stb && $stable(o_wb_we) && $stable(o_wb_data)));

endmodule

`default_nettype wire

/* hdl/lcd_subsystem.sv */
`default_nettype none

module lcd_subsystem import lcd_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst_n,
    // Host bus
    input  logic             i_wb_cyc,
    input  logic             i_wb_stb,
    input  logic             i_wb_we,
    input  logic [WB_AW-1:0] i_wb_addr,
    input  logic [WB_DW-1:0] i_wb_data,
    output logic             o_wb_ack,
    output logic             o_wb_stall,
    output logic [WB_DW-1:0] o_wb_data,
    // Display pins with the pad left to the board
    input  logic [7:0]       i_disp_data,
    output logic [7:0]       o_disp_data,
    output logic             o_disp_rw,
    output logic             o_disp_en,
    output logic             o_disp_rs,
    output logic             o_disp_on,
    output logic             o_disp_blon,
    output logic             o_init_done
);

    // Sequencer side
    logic             seq_cyc, seq_stb, seq_we;
    logic [WB_AW-1:0] seq_addr;
    logic [WB_DW-1:0] seq_wdata;
    logic             seq_ack, seq_stall;
    logic [WB_DW-1:0] seq_rdata;

    // Shared slave side
    logic             s_cyc, s_stb, s_we;
    logic [WB_AW-1:0] s_addr;
    logic [WB_DW-1:0] s_wdata;
    logic             s_ack, s_stall;
    logic [WB_DW-1:0] s_rdata;

    lcd_init_sequencer u_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_ack    (seq_ack),
        .i_wb_stall  (seq_stall),
        .i_wb_data   (seq_rdata),
        .o_wb_cyc    (seq_cyc),
        .o_wb_stb    (seq_stb),
        .o_wb_we     (seq_we),
        .o_wb_addr   (seq_addr),
        .o_wb_data   (seq_wdata),
        .o_init_done (o_init_done)
    );

    // Sequencer is master 0 and the host is master 1
    wb_rr_arbiter u_arb (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_m0_cyc   (seq_cyc),
        .i_m0_stb   (seq_stb),
        .i_m0_we    (seq_we),
        .i_m0_addr  (seq_addr),
        .i_m0_data  (seq_wdata),
        .o_m0_ack   (seq_ack),
        .o_m0_stall (seq_stall),
        .o_m0_data  (seq_rdata),
        .i_m1_cyc   (i_wb_cyc),
        .i_m1_stb   (i_wb_stb),
        .i_m1_we    (i_wb_we),
        .i_m1_addr  (i_wb_addr),
        .i_m1_data  (i_wb_data),
        .o_m1_ack   (o_wb_ack),
        .o_m1_stall (o_wb_stall),
        .o_m1_data  (o_wb_data),
        .i_s_ack    (s_ack),
        .i_s_stall  (s_stall),
        .i_s_data   (s_rdata),
        .o_s_cyc    (s_cyc),
        .o_s_stb    (s_stb),
        .o_s_we     (s_we),
        .o_s_addr   (s_addr),
        .o_s_data   (s_wdata)
    );

    lcd_hd44780_bus u_lcd (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (s_cyc),
        .i_wb_stb    (s_stb),
        .i_wb_we     (s_we),
        .i_wb_addr   (s_addr),
        .i_wb_data   (s_wdata),
        .i_disp_data (i_disp_data),
        .o_wb_ack    (s_ack),
        .o_wb_stall  (s_stall),
        .o_wb_data   (s_rdata),
        .o_disp_data (o_disp_data),
        .o_disp_rw   (o_disp_rw),
        .o_disp_en   (o_disp_en),
        .o_disp_rs   (o_disp_rs),
        .o_disp_on   (o_disp_on),
        .o_disp_blon (o_disp_blon)
    );

endmodule

`default_nettype wire

/* test/lcd_checker.sv */
module lcd_checker import lcd_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_disp_en,
    input  logic             i_disp_rs,
    input  logic             i_disp_rw,
    input  logic             i_disp_on,
    input  logic             i_disp_blon,
    input  logic [7:0]       i_disp_data,
    input  logic [7:0]       i_pin_data,
    input  logic             i_wb_cyc,
    input  logic             i_wb_stb,
    input  logic             i_wb_we,
    input  logic             i_wb_rs,
    input  logic [7:0]       i_wb_data,
    input  logic             i_wb_ack,
    input  logic             i_wb_stall,
    input  logic [WB_DW-1:0] i_wb_rdata,
    input  logic             i_init_done,
    input  logic             i_seq_rd_acc,
    input  logic             i_seq_owns,
    input  int               i_busy_total,
    input  logic             i_end,
    output int               o_errors,
    output int               o_checks,
    output logic             o_final_done
);

    logic       q_we [$];
    logic [8:0] q_byte [$];     // Expected {rs, byte} per request
    logic [8:0] pulse_q [$];    // Host pulses as {rs, data}
    logic       en_d, init_d, rst_chk, rs_cap, we_cur;
    logic [7:0] data_cap;
    logic [8:0] byte_cur;
    logic [8:0] pulse;
    int         cycle, rise_cyc, fall_cyc, init_idx, status_reads, n_req, n_ack;

    initial begin
        o_errors     = 0;
        o_checks     = 0;
        o_final_done = 1'b0;
        cycle        = 0;
        init_idx     = 0;
        status_reads = 0;
        n_req        = 0;
        n_ack        = 0;
        rise_cyc     = 0;
        fall_cyc     = 0;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        o_checks++;
        if (exp !== act) begin
            o_errors++;
            $display("** Error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic fail(input string what);
        o_errors++;
        $display("Failure: %s", what);
    endtask

    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            en_d    = 1'b0;
            init_d  = 1'b0;
            rst_chk = 1'b1;
        end else begin
            cycle++;
            if (rst_chk) begin
                check("reset en", 32'd0, 32'(i_disp_en));
                check("reset rw", 32'd1, 32'(i_disp_rw));
                check("reset init_done", 32'd0, 32'(i_init_done));
                check("reset ack", 32'd0, 32'(i_wb_ack));
                check("reset disp_on", 32'd1, 32'(i_disp_on));
                check("reset disp_blon", 32'd1, 32'(i_disp_blon));
                rst_chk = 1'b0;
                $display("Test reset state finished");
            end
            if (i_disp_en && !en_d) begin
                rise_cyc = cycle;
                rs_cap   = i_disp_rs;
                data_cap = i_disp_data;
            end
            if (!i_disp_en && en_d) begin
                fall_cyc = cycle;
                check("enable width", 32'(CMD_DELAY - CMD_DELAY / 2), 32'(cycle - rise_cyc));
                if (!rs_cap && !i_init_done) begin
                    if (init_idx < INIT_LEN) begin
                        check($sformatf("init cmd %0d", init_idx),
                              32'(INIT_CMDS[init_idx]), 32'(data_cap));
                    end else begin
                        fail("more command writes than the set-up list holds");
                    end
                    init_idx++;
                end else begin
                    pulse_q.push_back({rs_cap, data_cap});
                end
            end
            if (i_seq_owns && !i_wb_stall) fail("host not stalled while sequencer owns bus");
            if (i_seq_rd_acc) status_reads++;
            if (i_init_done && !init_d) begin
                check("init cmd count", 32'(INIT_LEN), 32'(init_idx));
                check("status reads", 32'(INIT_LEN + i_busy_total), 32'(status_reads));
                $display("Test initialisation finished");
            end
            if (i_wb_cyc && i_wb_stb && !i_wb_stall) begin
                q_we.push_back(i_wb_we);
                // Read expects held pins
                q_byte.push_back(i_wb_we ? {i_wb_rs, i_wb_data} : {1'b0, i_pin_data});
                n_req++;
            end
            if (i_wb_ack) begin
                n_ack++;
                if (q_we.size() == 0) begin
                    fail("host ack with no outstanding request");
                end else begin
                    we_cur   = q_we.pop_front();
                    byte_cur = q_byte.pop_front();
                    if (we_cur) begin
                        check("write ack timing", 32'(fall_cyc + 1), 32'(cycle));
                        if (pulse_q.size() == 0) begin
                            fail("host write acked without an enable pulse");
                        end else begin
                            pulse = pulse_q.pop_front();
                            check("write pulse", {23'h0, byte_cur}, {23'h0, pulse});
                        end
                    end else begin
                        check("read data", {24'h0, byte_cur[7:0]}, i_wb_rdata);
                    end
                    $display("Test host %s %0d finished", we_cur ? "write" : "read", n_ack);
                end
            end
            if (i_end && !o_final_done) begin
                check("ack count", 32'(n_req), 32'(n_ack));
                if (pulse_q.size() != 0) fail("enable pulses left without a host ack");
                if (!i_init_done) fail("initialisation never finished");
                $display("Test contention finished");
                o_final_done = 1'b1;
            end
            en_d   = i_disp_en;
            init_d = i_init_done;
        end
    end

endmodule

/* test/tb_lcd_subsystem.sv */
module tb_lcd_subsystem import lcd_pkg::*; ();

    localparam int N_OPS   = 24;
    localparam int TIMEOUT = (INIT_LEN + N_OPS) * (CMD_DELAY + 20) + 500;

    logic             clk;
    logic             rst_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [WB_AW-1:0] wb_addr;
    logic [WB_DW-1:0] wb_data;
    logic             wb_ack;
    logic             wb_stall;
    logic [WB_DW-1:0] wb_rdata;
    logic [7:0]       disp_in;
    logic [7:0]       disp_out;
    logic             disp_rw, disp_en, disp_rs, disp_on, disp_blon, init_done;

    logic [31:0] lcg_state  = 32'h3581;
    logic [7:0]  data_byte  = 8'h00;
    int          busy_cnt   = 0;
    int          busy_total = 0;
    int          cycles     = 0;
    int          errors;
    int          checks;
    logic        run_end    = 1'b0;
    logic        final_done;

    lcd_subsystem UUT (
        .i_clk (clk), .i_rst_n (rst_n),
        .i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb), .i_wb_we (wb_we),
        .i_wb_addr (wb_addr), .i_wb_data (wb_data),
        .o_wb_ack (wb_ack), .o_wb_stall (wb_stall), .o_wb_data (wb_rdata),
        .i_disp_data (disp_in), .o_disp_data (disp_out), .o_disp_rw (disp_rw),
        .o_disp_en (disp_en), .o_disp_rs (disp_rs), .o_disp_on (disp_on),
        .o_disp_blon (disp_blon), .o_init_done (init_done)
    );

    lcd_checker u_checker (
        .i_clk (clk), .i_rst_n (rst_n),
        .i_disp_en (disp_en), .i_disp_rs (disp_rs), .i_disp_rw (disp_rw),
        .i_disp_on (disp_on), .i_disp_blon (disp_blon),
        .i_disp_data (disp_out), .i_pin_data (disp_in),
        .i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb), .i_wb_we (wb_we), .i_wb_rs (wb_addr[0]),
        .i_wb_data (wb_data[7:0]), .i_wb_ack (wb_ack), .i_wb_stall (wb_stall),
        .i_wb_rdata (wb_rdata), .i_init_done (init_done),
        .i_seq_rd_acc (UUT.seq_stb && !UUT.seq_stall && !UUT.seq_we),
        .i_seq_owns (UUT.u_arb.busy && !UUT.u_arb.owner),
        .i_busy_total (busy_total), .i_end (run_end),
        .o_errors (errors), .o_checks (checks), .o_final_done (final_done)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_val(output logic [31:0] r);
        lcg_state = lcg_next(lcg_state);
        r = {16'h0, lcg_state[31:16]};  // Upper bits are the better ones
    endtask

    // Busy flag in status mode and the held byte once init is over
    assign disp_in = init_done ? data_byte : ((busy_cnt != 0) ? 8'(1 << BUSY_BIT) : 8'h00);

    always @(negedge clk) begin
        if (UUT.seq_stb && !UUT.seq_stall) begin
            if (UUT.seq_we) begin
                lcg_state  = lcg_next(lcg_state);
                busy_cnt   = int'(lcg_state[17:16]);  // 0 to 3 busy reads
                busy_total += busy_cnt;
            end else if (busy_cnt > 0) begin
                busy_cnt--;
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout after %0d cycles, the bus or the sequencer stopped", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic bus_xfer(input logic we, input logic rs, input logic [7:0] val);
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = we;
        wb_addr = WB_AW'(rs);     // Register select on address bit 0
        wb_data = {24'h0, val};
        do @(negedge clk); while (wb_stall);
        @(posedge clk);
        #1;
        wb_stb = 1'b0;
        do @(negedge clk); while (!wb_ack);
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_we  = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] v;
        logic        rs;
        rst_n   = 1'b0;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < N_OPS; i++) begin
            rand_val(r);
            if (r[2:0] != 3'd0) begin
                repeat (int'(r[2:0])) @(posedge clk);
                #1;
            end
            rand_val(r);
            rand_val(v);
            rs = init_done ? r[1] : 1'b1;    // Data register only during init
            if (init_done && r[0]) begin
                data_byte = v[7:0];
                repeat (3) @(posedge clk);   // Let the synchroniser settle
                #1;
                bus_xfer(1'b0, rs, 8'h00);
            end else begin
                bus_xfer(1'b1, rs, v[7:0]);
            end
        end
        wait (init_done);
        repeat (5) @(posedge clk);
        run_end = 1'b1;
        wait (final_done);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* project.f */
hdl/lcd_pkg.sv
hdl/lcd_hd44780_bus.sv
hdl/wb_rr_arbiter.sv
hdl/lcd_init_sequencer.sv
hdl/lcd_subsystem.sv
test/lcd_checker.sv
test/tb_lcd_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LCD subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module tb_lcd_subsystem -o sim_lcd
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_lcd)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
